// ==== logic/rv_pkg.sv ====
//----------------------------------------------------------
// rv_pkg: shared RV32I opcodes, control encodings, the
// instruction-format union and the controller bundle
//----------------------------------------------------------
package rv_pkg;

  localparam int xlen = 32;  // word width fixed by rv32i

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opcode_load     = 7'b0000011,
    opcode_misc_mem = 7'b0001111,  // fence, runs as a no-op
    opcode_op_imm   = 7'b0010011,
    opcode_auipc    = 7'b0010111,
    opcode_store    = 7'b0100011,
    opcode_op       = 7'b0110011,
    opcode_lui      = 7'b0110111,
    opcode_branch   = 7'b1100011,
    opcode_jalr     = 7'b1100111,
    opcode_jal      = 7'b1101111
  } opcode_e;

  typedef enum logic [1:0] {
    pc_plus4, pc_plus_imm, rs1_plus_imm
  } ctl_pc_e;  // next-pc source

  typedef enum logic {alu_a_rs1, alu_a_pc} ctl_alu_a_e;
  typedef enum logic {alu_b_rs2, alu_b_imm} ctl_alu_b_e;

  typedef enum logic [1:0] {
    alu_type_add, alu_type_op, alu_type_op_imm, alu_type_branch
  } ctl_alu_type_e;  // coarse op, refined by alu_control

  typedef enum logic [2:0] {wb_alu, wb_imm, wb_pc4, wb_data} ctl_wb_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_func_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one fetched word, viewed in each base format
  typedef union packed {
    r_fmt_t      r_fmt;
    i_fmt_t      i_fmt;
    s_fmt_t      s_fmt;
    b_fmt_t      b_fmt;
    u_fmt_t      u_fmt;
    j_fmt_t      j_fmt;
    logic [31:0] raw;
  } inst_t;

  // controller outputs to the datapath
  typedef struct packed {
    ctl_pc_e       next_pc_select;
    logic          regfile_write_enable;
    ctl_alu_a_e    alu_operand_a_select;
    ctl_alu_b_e    alu_operand_b_select;
    ctl_alu_type_e alu_op_type;
    logic          data_mem_read_enable;
    logic          data_mem_write_enable;
    ctl_wb_e       reg_writeback_select;
  } ctl_t;

endpackage

// ==== logic/regfile.sv ====
//----------------------------------------------------------
// regfile: 32 x 32 registers, two async reads, one write,
// x0 hardwired to zero
//----------------------------------------------------------
`timescale 1ns/1ps

module regfile (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic [4:0]               rs1_addr,
  input  logic [4:0]               rs2_addr,
  input  logic [4:0]               rd_addr,
  input  logic [rv_pkg::xlen-1:0]  rd_data,
  input  logic                     write_enable,
  output logic [rv_pkg::xlen-1:0]  rs1_data,
  output logic [rv_pkg::xlen-1:0]  rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [1:31];  // no storage behind x0

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;  // writes to x0 dropped
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== logic/imm_decoder.sv ====
//----------------------------------------------------------
// imm_decoder: pulls the immediate out of the format that
// matches the opcode and sign-extends it to a full word
//----------------------------------------------------------
`timescale 1ns/1ps

module imm_decoder (
  input  rv_pkg::inst_t            inst,
  output logic [rv_pkg::xlen-1:0]  imm
);

  always_comb begin
    case (inst.r_fmt.opcode)
      rv_pkg::opcode_lui, rv_pkg::opcode_auipc:
        imm = {inst.u_fmt.imm_31_12, 12'b0};  // upper 20 bits, low half zero
      rv_pkg::opcode_jal:
        imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
               inst.j_fmt.imm_10_1, 1'b0};  // halfword offset
      rv_pkg::opcode_branch:
        imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
               inst.b_fmt.imm_4_1, 1'b0};
      rv_pkg::opcode_store:
        imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
      default:
        imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};  // op_imm, load, jalr
    endcase
  end

endmodule

// ==== logic/alu.sv ====
//----------------------------------------------------------
// alu: 32-bit integer alu, also resolves branch compares
//----------------------------------------------------------
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_func_e        alu_func,
  input  logic [rv_pkg::xlen-1:0]  operand_a,
  input  logic [rv_pkg::xlen-1:0]  operand_b,
  output logic [rv_pkg::xlen-1:0]  result,
  output logic                     take_branch
);

  logic [4:0] shamt;  // rv32 shifts use five bits
  logic       lt_s;   // signed less-than
  logic       lt_u;   // unsigned less-than
  logic       eq;

  assign shamt = operand_b[4:0];
  assign lt_s  = $signed(operand_a) < $signed(operand_b);
  assign lt_u  = operand_a < operand_b;
  assign eq    = operand_a == operand_b;

  always_comb begin
    result      = '0;  // compares leave result at zero
    take_branch = 1'b0;
    case (alu_func)
      rv_pkg::alu_add:  result = operand_a + operand_b;
      rv_pkg::alu_sub:  result = operand_a - operand_b;
      rv_pkg::alu_sll:  result = operand_a << shamt;
      rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
      rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
      rv_pkg::alu_xor:  result = operand_a ^ operand_b;
      rv_pkg::alu_srl:  result = operand_a >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(operand_a) >>> shamt);
      rv_pkg::alu_or:   result = operand_a | operand_b;
      rv_pkg::alu_and:  result = operand_a & operand_b;
      rv_pkg::alu_beq:  take_branch = eq;
      rv_pkg::alu_bne:  take_branch = !eq;
      rv_pkg::alu_blt:  take_branch = lt_s;
      rv_pkg::alu_bge:  take_branch = !lt_s;
      rv_pkg::alu_bltu: take_branch = lt_u;
      rv_pkg::alu_bgeu: take_branch = !lt_u;
      default:          result = '0;
    endcase
  end

endmodule

// ==== logic/singlecycle_datapath.sv ====
//----------------------------------------------------------
// singlecycle_datapath: pc register, operand and writeback
// muxes, next-pc select around regfile, imm decoder and alu
//----------------------------------------------------------
`timescale 1ns/1ps

module singlecycle_datapath #(
  parameter logic [rv_pkg::xlen-1:0] reset_vector = '0
) (
  input  logic                     clock,
  input  logic                     rst_n,
  input  rv_pkg::inst_t            inst,
  input  rv_pkg::ctl_t             ctl,
  input  rv_pkg::alu_func_e        alu_func,
  output logic                     take_branch,
  output logic [rv_pkg::xlen-1:0]  inst_addr,
  output logic [rv_pkg::xlen-1:0]  data_addr,
  output logic [rv_pkg::xlen-1:0]  data_wdata,
  input  logic [rv_pkg::xlen-1:0]  data_rdata
);

  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] next_pc;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] pc_plus_imm;  // branch/jal target
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] rd_data;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] operand_a;
  logic [rv_pkg::xlen-1:0] operand_b;
  logic [rv_pkg::xlen-1:0] alu_result;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= reset_vector;
    end else begin
      pc <= next_pc;  // one instruction per edge
    end
  end

  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  always_comb begin
    case (ctl.next_pc_select)
      rv_pkg::pc_plus_imm:  next_pc = pc_plus_imm;
      rv_pkg::rs1_plus_imm: next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};  // jalr
      default:              next_pc = pc_plus4;
    endcase
  end

  regfile u_regfile (
    .clock        (clock),
    .rst_n        (rst_n),
    .rs1_addr     (inst.r_fmt.rs1),
    .rs2_addr     (inst.r_fmt.rs2),
    .rd_addr      (inst.r_fmt.rd),
    .rd_data      (rd_data),
    .write_enable (ctl.regfile_write_enable),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  imm_decoder u_imm_decoder (
    .inst (inst),
    .imm  (imm)
  );

  assign operand_a = (ctl.alu_operand_a_select == rv_pkg::alu_a_pc) ? pc : rs1_data;
  assign operand_b = (ctl.alu_operand_b_select == rv_pkg::alu_b_imm) ? imm : rs2_data;

  alu u_alu (
    .alu_func    (alu_func),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  always_comb begin
    case (ctl.reg_writeback_select)
      rv_pkg::wb_imm:  rd_data = imm;  // lui
      rv_pkg::wb_pc4:  rd_data = pc_plus4;  // jal/jalr link
      rv_pkg::wb_data: rd_data = data_rdata;
      default:         rd_data = alu_result;
    endcase
  end

  assign inst_addr  = pc;
  assign data_addr  = alu_result;  // rs1 + imm on loads and stores
  assign data_wdata = rs2_data;

endmodule

// ==== logic/singlecycle_control.sv ====
//----------------------------------------------------------
// singlecycle_control: main decoder, turns the major opcode
// and the branch outcome into datapath control
//----------------------------------------------------------
`timescale 1ns/1ps

module singlecycle_control (
  input  logic            clock,
  input  rv_pkg::opcode_e inst_opcode,
  input  logic            take_branch,
  output rv_pkg::ctl_t    ctl
);

  always_comb begin
    // defaults describe a harmless no-op
    ctl.next_pc_select        = rv_pkg::pc_plus4;
    ctl.regfile_write_enable  = 1'b0;
    ctl.alu_operand_a_select  = rv_pkg::alu_a_rs1;
    ctl.alu_operand_b_select  = rv_pkg::alu_b_imm;
    ctl.alu_op_type           = rv_pkg::alu_type_add;
    ctl.data_mem_read_enable  = 1'b0;
    ctl.data_mem_write_enable = 1'b0;
    ctl.reg_writeback_select  = rv_pkg::wb_alu;
    case (inst_opcode)
      rv_pkg::opcode_lui: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = rv_pkg::wb_imm;  // imm already shifted up
      end
      rv_pkg::opcode_auipc: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = rv_pkg::alu_a_pc;  // pc + upper imm
      end
      rv_pkg::opcode_jal: begin
        ctl.next_pc_select       = rv_pkg::pc_plus_imm;
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = rv_pkg::alu_a_pc;
        ctl.reg_writeback_select = rv_pkg::wb_pc4;  // link
      end
      rv_pkg::opcode_jalr: begin
        ctl.next_pc_select       = rv_pkg::rs1_plus_imm;  // target from alu sum
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = rv_pkg::wb_pc4;
      end
      rv_pkg::opcode_branch: begin
        ctl.next_pc_select       = take_branch ? rv_pkg::pc_plus_imm : rv_pkg::pc_plus4;
        ctl.alu_operand_b_select = rv_pkg::alu_b_rs2;  // compare rs1 with rs2
        ctl.alu_op_type          = rv_pkg::alu_type_branch;
      end
      rv_pkg::opcode_load: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.data_mem_read_enable = 1'b1;  // address = rs1 + imm
        ctl.reg_writeback_select = rv_pkg::wb_data;
      end
      rv_pkg::opcode_store: begin
        ctl.data_mem_write_enable = 1'b1;
      end
      rv_pkg::opcode_op_imm: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_op_type          = rv_pkg::alu_type_op_imm;
      end
      rv_pkg::opcode_op: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = rv_pkg::alu_b_rs2;
        ctl.alu_op_type          = rv_pkg::alu_type_op;
      end
      rv_pkg::opcode_misc_mem: begin
        ctl.regfile_write_enable = 1'b0;  // fence, nothing to order here
      end
      default: begin
        ctl                       = 'x;  // selects are don't care
        ctl.next_pc_select        = rv_pkg::pc_plus4;  // keep fetching
        ctl.regfile_write_enable  = 1'b0;
        ctl.data_mem_read_enable  = 1'b0;  // never touch memory
        ctl.data_mem_write_enable = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/alu_control.sv ====
//----------------------------------------------------------
// alu_control: refines the coarse alu op type with funct3
// and funct7 bit 5 into a concrete alu function
//----------------------------------------------------------
`timescale 1ns/1ps

module alu_control (
  input  rv_pkg::ctl_alu_type_e alu_op_type,
  input  logic [2:0]            funct3,
  input  logic                  funct7_5,
  output rv_pkg::alu_func_e     alu_func
);

  always_comb begin
    logic alt_add;  // sub instead of add, register form only
    alt_add  = funct7_5 && (alu_op_type == rv_pkg::alu_type_op);
    alu_func = rv_pkg::alu_add;
    case (alu_op_type)
      rv_pkg::alu_type_op, rv_pkg::alu_type_op_imm: begin
        case (funct3)
          3'b000: alu_func = alt_add ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'b001: alu_func = rv_pkg::alu_sll;
          3'b010: alu_func = rv_pkg::alu_slt;
          3'b011: alu_func = rv_pkg::alu_sltu;
          3'b100: alu_func = rv_pkg::alu_xor;
          3'b101: alu_func = funct7_5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;  // both forms
          3'b110: alu_func = rv_pkg::alu_or;
          default: alu_func = rv_pkg::alu_and;
        endcase
      end
      rv_pkg::alu_type_branch: begin
        case (funct3)
          3'b000: alu_func = rv_pkg::alu_beq;
          3'b001: alu_func = rv_pkg::alu_bne;
          3'b100: alu_func = rv_pkg::alu_blt;
          3'b101: alu_func = rv_pkg::alu_bge;
          3'b110: alu_func = rv_pkg::alu_bltu;
          3'b111: alu_func = rv_pkg::alu_bgeu;
          default: alu_func = rv_pkg::alu_add;  // reserved, never taken
        endcase
      end
      default: alu_func = rv_pkg::alu_add;  // address and pc sums
    endcase
  end

endmodule

// ==== logic/rv_simple_core.sv ====
//----------------------------------------------------------
// rv_simple_core: rv32i single-cycle core, controller plus
// datapath wired to the fetch and data ports
//----------------------------------------------------------
`timescale 1ns/1ps

module rv_simple_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_vector = '0
) (
  input  logic                     clock,
  input  logic                     rst_n,
  output logic [rv_pkg::xlen-1:0]  inst_addr,
  input  rv_pkg::inst_t            inst,
  output logic [rv_pkg::xlen-1:0]  data_addr,
  output logic [rv_pkg::xlen-1:0]  data_wdata,
  input  logic [rv_pkg::xlen-1:0]  data_rdata,
  output logic                     data_read_enable,
  output logic                     data_write_enable
);

  rv_pkg::ctl_t      ctl;
  rv_pkg::alu_func_e alu_func;
  logic              take_branch;  // compare result back to the decoder

  singlecycle_control u_control (
    .clock       (clock),
    .inst_opcode (inst.r_fmt.opcode),
    .take_branch (take_branch),
    .ctl         (ctl)
  );

  alu_control u_alu_control (
    .alu_op_type (ctl.alu_op_type),
    .funct3      (inst.r_fmt.funct3),
    .funct7_5    (inst.r_fmt.funct7[5]),
    .alu_func    (alu_func)
  );

  singlecycle_datapath #(
    .reset_vector (reset_vector)
  ) u_datapath (
    .clock       (clock),
    .rst_n       (rst_n),
    .inst        (inst),
    .ctl         (ctl),
    .alu_func    (alu_func),
    .take_branch (take_branch),
    .inst_addr   (inst_addr),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_rdata  (data_rdata)
  );

  assign data_read_enable  = ctl.data_mem_read_enable;
  assign data_write_enable = ctl.data_mem_write_enable;  // memory ignores it in reset

endmodule

// ==== tb/rv_checker.sv ====
//----------------------------------------------------------
// rv_checker: rv32i reference model, steps one instruction
// per edge and compares pc and data-port traffic
//----------------------------------------------------------
`timescale 1ns/1ps

module rv_checker #(
  parameter int          prog_len     = 200,
  parameter int          data_words   = 256,
  parameter logic [31:0] reset_vector = '0
) (
  input logic        clock,
  input logic        rst_n,
  input logic [31:0] inst_addr,
  input logic [31:0] data_addr,
  input logic [31:0] data_wdata,
  input logic [31:0] data_rdata,
  input logic        data_read_enable,
  input logic        data_write_enable
);

  logic [31:0] prog [0:prog_len-1];    // program copy, loaded by the tb top
  logic [31:0] mem  [0:data_words-1];  // data memory copy
  logic [31:0] regs [0:31];
  int          reg_beh [0:31];         // behavior the register value belongs to
  logic [31:0] pc_m;                   // model pc
  int          pc_beh;                 // behavior of the next pc check
  int          checks [1:6];
  int          errors [1:6];

  initial begin
    for (int k = 1; k <= 6; k++) begin
      checks[k] = 0;
      errors[k] = 0;
    end
  end

  task automatic compare_word(input int beh, input string name,
                              input logic [31:0] expected, input logic [31:0] actual);
    checks[beh]++;
    if (actual !== expected) begin
      errors[beh]++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // integer ops per the rv32i spec, alt is instruction bit 30
  function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  always @(posedge clock) begin
    logic [31:0] w, a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0] addr, val, next;
    logic        wr, taken;
    int          val_beh;
    if (!rst_n) begin
      pc_m   = reset_vector;
      pc_beh = 1;
      for (int r = 0; r < 32; r++) begin
        regs[r]    = '0;
        reg_beh[r] = (r == 0) ? 6 : 2;  // x0 stores count as behavior 6
      end
    end else begin
      w     = prog[(pc_m - reset_vector) >> 2];
      a     = regs[w[19:15]];
      b     = regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_u = {w[31:12], 12'b0};
      imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      addr    = a + imm_i;  // load address
      next    = pc_m + 32'd4;
      wr      = 1'b1;
      val     = '0;
      val_beh = 2;
      taken   = 1'b0;
      compare_word(pc_beh, "inst_addr", pc_m, inst_addr);
      pc_beh = 1;
      case (w[6:0])
        7'h37: val = imm_u;  // lui
        7'h17: val = pc_m + imm_u;  // auipc
        7'h13: val = model_alu(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm_i);
        7'h33: val = model_alu(w[14:12], w[30], a, b);
        7'h6f: begin  // jal
          val     = pc_m + 32'd4;
          val_beh = 5;
          next    = pc_m + imm_j;
          pc_beh  = 5;
        end
        7'h67: begin  // jalr, bit 0 dropped
          val     = pc_m + 32'd4;
          val_beh = 5;
          next    = (a + imm_i) & ~32'd1;
          pc_beh  = 5;
        end
        7'h63: begin
          wr     = 1'b0;
          pc_beh = 4;
          case (w[14:12])
            3'd0: taken = a == b;
            3'd1: taken = a != b;
            3'd4: taken = $signed(a) < $signed(b);
            3'd5: taken = $signed(a) >= $signed(b);
            3'd6: taken = a < b;
            3'd7: taken = a >= b;
            default: taken = 1'b0;
          endcase
          if (taken) begin
            next = pc_m + imm_b;
          end
        end
        7'h03: begin  // lw
          val     = mem[(addr >> 2) % data_words];
          val_beh = 3;
          compare_word(3, "data_addr", addr, data_addr);
          compare_word(3, "data_rdata", val, data_rdata);
        end
        7'h23: begin  // sw
          wr   = 1'b0;
          addr = a + imm_s;
          compare_word(3, "data_addr", addr, data_addr);
          compare_word(reg_beh[w[24:20]], "data_wdata", b, data_wdata);
          mem[(addr >> 2) % data_words] = b;
        end
        default: wr = 1'b0;  // fence
      endcase
      compare_word(3, "data_read_enable", {31'b0, w[6:0] == 7'h03},
                   {31'b0, data_read_enable});
      compare_word(3, "data_write_enable", {31'b0, w[6:0] == 7'h23},
                   {31'b0, data_write_enable});
      if (wr && (w[11:7] != 5'd0)) begin
        regs[w[11:7]]    = val;
        reg_beh[w[11:7]] = val_beh;
      end
      pc_m = next;
    end
  end

endmodule

// ==== tb/tb_rv_simple.sv ====
//----------------------------------------------------------
// tb_rv_simple: testbench for the single-cycle core, random
// forward-only program, memory models and a reference checker
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_rv_simple;

  localparam int          prog_len     = 200;
  localparam int          data_words   = 256;
  localparam logic [31:0] reset_vector = 32'h0;
  localparam int          cycle_limit  = prog_len * 2 + 20;
  localparam logic [31:0] final_addr   = reset_vector + 4 * (prog_len - 1);

  logic          clock;
  logic          rst_n;
  logic [31:0]   inst_addr;
  rv_pkg::inst_t inst;
  logic [31:0]   data_addr;
  logic [31:0]   data_wdata;
  logic [31:0]   data_rdata;
  logic          data_read_enable;
  logic          data_write_enable;

  logic [31:0] imem [0:prog_len-1];
  logic [31:0] dmem [0:data_words-1];
  integer      seed;
  int          cycles;
  int          loop_cycles;  // edges spent in the final jal loop

  rv_simple_core #(.reset_vector(reset_vector)) dut0 (
    .clock             (clock),
    .rst_n             (rst_n),
    .inst_addr         (inst_addr),
    .inst              (inst),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .data_rdata        (data_rdata),
    .data_read_enable  (data_read_enable),
    .data_write_enable (data_write_enable)
  );

  rv_checker #(
    .prog_len     (prog_len),
    .data_words   (data_words),
    .reset_vector (reset_vector)
  ) check0 (
    .clock             (clock),
    .rst_n             (rst_n),
    .inst_addr         (inst_addr),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .data_rdata        (data_rdata),
    .data_read_enable  (data_read_enable),
    .data_write_enable (data_write_enable)
  );

  // both memories answer in the same cycle
  assign inst       = imem[(inst_addr - reset_vector) >> 2];
  assign data_rdata = dmem[(data_addr >> 2) % data_words];

  always @(posedge clock) begin
    if (rst_n && data_write_enable) begin
      dmem[(data_addr >> 2) % data_words] <= data_wdata;
    end
  end

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};  // sw only
  endfunction

  function automatic logic [31:0] b_type_word(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic build_program();
    int          i;
    int          room;
    int          hop;
    int          b3;
    int          reach;  // furthest slot an earlier jump can land on
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [31:0] target, upper;
    for (int r = 1; r < 16; r++) begin  // lui/addi prologue seeds x1..x15
      imem[2*r-2] = u_type_word(20'(rand_below(1 << 20)), 5'(r), 7'h37);
      imem[2*r-1] = i_type_word(12'(rand_below(4096)), 5'(r), 3'd0, 5'(r), 7'h13);
    end
    imem[30] = i_type_word(12'h5a5, 5'd0, 3'd0, 5'd0, 7'h13);  // addi x0, dropped
    imem[31] = s_type_word(12'(4 * rand_below(data_words)), 5'd0, 5'd0);
    imem[32] = j_type_word(21'd4, 5'd5);  // jal x5 to next, link into x5
    imem[33] = s_type_word(12'(4 * rand_below(data_words)), 5'd5, 5'd0);
    reach = 33;
    i = 34;
    while (i < prog_len - 1) begin
      rd   = 5'(rand_below(16));
      rs1  = 5'(1 + rand_below(15));
      rs2  = 5'(1 + rand_below(15));
      f3   = 3'(rand_below(8));
      room = prog_len - 1 - i;  // slots left before the final loop
      hop  = 1 + rand_below((room < 4) ? room : 4);
      case (rand_below(17))
        0, 1, 2, 3: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) != 0) ? 7'h20 : 7'h00;
          imem[i] = r_type_word(f7, rs2, rs1, f3, rd, 7'h33);
        end
        4, 5, 6: begin
          imm = 12'(rand_below(4096));
          if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
          if (f3 == 3'd5) imm = {(rand_below(2) != 0) ? 7'h20 : 7'h00, imm[4:0]};
          imem[i] = i_type_word(imm, rs1, f3, rd, 7'h13);
        end
        7: imem[i] = u_type_word(20'(rand_below(1 << 20)), rd, 7'h37);
        8: imem[i] = u_type_word(20'(rand_below(1 << 20)), rd, 7'h17);
        9: imem[i] = i_type_word(12'(4 * rand_below(data_words)), 5'd0, 3'd2, rd, 7'h03);
        10, 11: imem[i] = s_type_word(12'(4 * rand_below(data_words)), rd, 5'd0);
        12, 13: begin
          b3 = rand_below(6);
          if (rand_below(4) == 0) rs2 = rs1;  // equal operands now and then
          imem[i] = b_type_word(13'(4 * hop), rs2, rs1, 3'((b3 < 2) ? b3 : b3 + 2));
          if (i + hop > reach) reach = i + hop;
        end
        14: begin
          imem[i] = j_type_word(21'(4 * hop), rd);
          if (i + hop > reach) reach = i + hop;
        end
        15: begin
          if (room >= 3 && reach <= i) begin  // lui/addi/jalr, entered only at the lui
            hop    = 1 + rand_below((room - 2 < 4) ? room - 2 : 4);
            target = reset_vector + 4 * (i + 2 + hop) + rand_below(2);
            upper  = (target + 32'h800) >> 12;
            imem[i]   = u_type_word(upper[19:0], rs1, 7'h37);
            imem[i+1] = i_type_word(target[11:0], rs1, 3'd0, rs1, 7'h13);
            imem[i+2] = i_type_word(12'h000, rs1, 3'd0, rd, 7'h67);
            reach = i + 2 + hop;
            i = i + 2;
          end else begin
            imem[i] = 32'h0ff0000f;
          end
        end
        default: imem[i] = 32'h0ff0000f;  // fence
      endcase
      i++;
    end
    imem[prog_len-1] = j_type_word(21'd0, 5'd0);  // jal x0 to self
    for (int k = 0; k < data_words; k++) begin
      dmem[k] = $random(seed);
    end
    for (int k = 0; k < prog_len; k++) check0.prog[k] = imem[k];
    for (int k = 0; k < data_words; k++) check0.mem[k] = dmem[k];
  endtask

  function automatic string behavior_title(input int k);
    case (k)
      1: return "pc sequencing";
      2: return "alu results";
      3: return "loads and stores";
      4: return "branches";
      5: return "jal and jalr";
      default: return "x0 writes";
    endcase
  endfunction

  task automatic report_results(output int failed);
    int total_checks;
    int total_errors;
    int missed;
    total_checks = 0;
    total_errors = 0;
    missed       = 0;
    for (int k = 1; k <= 6; k++) begin
      total_checks += check0.checks[k];
      total_errors += check0.errors[k];
      if (check0.checks[k] == 0) begin
        $display("behavior %0d, %s: never exercised by the program", k, behavior_title(k));
        missed++;
      end else begin
        $display("behavior %0d, %s: %0d checks, %0d errors", k, behavior_title(k),
                 check0.checks[k], check0.errors[k]);
      end
    end
    $display("done: %0d checks, %0d errors, %0d behaviors not exercised",
             total_checks, total_errors, missed);
    failed = total_errors + missed;
  endtask

  initial begin
    int failed;
    seed  = 63091;
    rst_n = 1'b0;
    build_program();
    repeat (2) @(posedge clock);
    rst_n       <= 1'b1;
    cycles      = 0;
    loop_cycles = 0;
    while (loop_cycles < 4 && cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
      if (inst_addr == final_addr) loop_cycles++;
    end
    @(negedge clock);  // checker has finished the last edge
    if (loop_cycles < 4) begin
      $display("timeout: the core did not reach the final loop within %0d cycles",
               cycle_limit);
      $display("TEST FAIL");
    end else begin
      report_results(failed);
      if (failed == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
    end
    $finish;
  end

endmodule

// ==== rv_simple.f ====
logic/rv_pkg.sv
logic/regfile.sv
logic/imm_decoder.sv
logic/alu.sv
logic/singlecycle_datapath.sv
logic/singlecycle_control.sv
logic/alu_control.sv
logic/rv_simple_core.sv
tb/rv_checker.sv
tb/tb_rv_simple.sv

// ==== Bender.yml ====
package:
  name: rv_simple

sources:
  - logic/rv_pkg.sv
  - logic/regfile.sv
  - logic/imm_decoder.sv
  - logic/alu.sv
  - logic/singlecycle_datapath.sv
  - logic/singlecycle_control.sv
  - logic/alu_control.sv
  - logic/rv_simple_core.sv
  - target: test
    files:
      - tb/rv_checker.sv
      - tb/tb_rv_simple.sv
